/* all.f */
+incdir+sim
design/div_pkg.sv
design/div_lane_dpath.sv
design/div_lane_ctrl.sv
design/div_lane.sv
design/div_wb_front.sv
design/div_collect.sv
design/div_array_top.sv
sim/div_array_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the divide coprocessor testbench with verilator
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir build.log sim.log

verilator --binary --timing -Wno-fatal -f all.f --top-module div_array_tb \
  -o div_array_tb_sim > build.log 2>&1 \
  || { cat build.log; echo "verilator build failed"; exit 1; }

./obj_dir/div_array_tb_sim > sim.log 2>&1 \
  || { cat sim.log; echo "simulation exited with an error"; exit 1; }

cat sim.log
grep -q "TB FAILED" sim.log && { echo "simulation reported failure"; exit 1; }
echo "simulation reported success"
exit 0

/* sim/div_tb_vectors.svh */
// divider stimulus table
// directed unsigned and signed rows, applied in bursts by the testbench
`ifndef DIV_TB_VECTORS_SVH
`define DIV_TB_VECTORS_SVH

// columns of a row: function, dividend a, divisor b, tag
// rows 0..11 are unsigned, rows 12..23 are signed

localparam int TABLE_ROWS    = 24;
localparam int UNSIGNED_ROWS = 12;
localparam int ROW_W         = 1 + 2 * DATA_W + TAG_W;

function automatic logic [ROW_W-1:0] vector_row(input int idx);
  logic [ROW_W-1:0] row;
  case (idx)
    // unsigned, plain, a below b, b of 1, b of 0, near all ones
    0:  row = {FN_UNSIGNED, 32'd100,        32'd7,          4'h0};
    1:  row = {FN_UNSIGNED, 32'd3,          32'd10,         4'h1};
    2:  row = {FN_UNSIGNED, 32'hdeadbeef,   32'd1,          4'h2};
    3:  row = {FN_UNSIGNED, 32'h12345678,   32'd0,          4'h3};
    4:  row = {FN_UNSIGNED, 32'hffffffff,   32'hfffffffe,   4'h4};
    5:  row = {FN_UNSIGNED, 32'hfffffffe,   32'hffffffff,   4'h5};
    6:  row = {FN_UNSIGNED, 32'hffffffff,   32'hffffffff,   4'h6};
    7:  row = {FN_UNSIGNED, 32'h80000000,   32'd2,          4'h7};
    8:  row = {FN_UNSIGNED, 32'd0,          32'd5,          4'h8};
    9:  row = {FN_UNSIGNED, 32'h7fffffff,   32'h00010000,   4'h9};
    10: row = {FN_UNSIGNED, 32'd1000000007, 32'd12345,      4'ha};
    11: row = {FN_UNSIGNED, 32'd0,          32'd0,          4'hb};
    // signed, four sign combinations
    12: row = {FN_SIGNED,   32'd100,        32'd7,          4'hc};
    13: row = {FN_SIGNED,   32'hffffff9c,   32'd7,          4'hd};
    14: row = {FN_SIGNED,   32'd100,        32'hfffffff9,   4'he};
    15: row = {FN_SIGNED,   32'hffffff9c,   32'hfffffff9,   4'hf};
    // most negative over minus one, then division by zero
    16: row = {FN_SIGNED,   32'h80000000,   32'hffffffff,   4'h0};
    17: row = {FN_SIGNED,   32'd55,         32'd0,          4'h1};
    18: row = {FN_SIGNED,   32'hffffffc9,   32'd0,          4'h2};
    19: row = {FN_SIGNED,   32'h80000000,   32'd1,          4'h3};
    20: row = {FN_SIGNED,   32'd7,          32'd100,        4'h4};
    21: row = {FN_SIGNED,   32'hfffffff9,   32'd100,        4'h5};
    22: row = {FN_SIGNED,   32'h7fffffff,   32'h80000000,   4'h6};
    23: row = {FN_SIGNED,   32'h80000000,   32'h80000000,   4'h7};
    default: row = '0;
  endcase
  return row;
endfunction

`endif

/* sim/div_array_tb.sv */
// testbench for the divide coprocessor
// wishbone accesses from a vector table and LFSR rows with results checked by tag
`timescale 1ns/1ps

module div_array_tb;

  import div_pkg::*;

  localparam int NUM_LANES    = 4;
  localparam int RESULT_DEPTH = 4;
  localparam int RAND_ROWS    = 40;
  localparam int BURST        = 4;
  localparam int POLL_LIMIT   = 100;
  localparam int NUM_TAGS     = 1 << TAG_W;
  // cycles from request transfer until a lane holds its response
  localparam int LANE_CYCLES  = 34;

  `include "div_tb_vectors.svh"

  // every row costs well under 60 cycles plus slack for reset and status reads
  localparam int CYCLE_LIMIT = (TABLE_ROWS + RAND_ROWS) * 60 + 500;
  localparam logic [STAT_MASK_W-1:0] ALL_IDLE = STAT_MASK_W'((1 << NUM_LANES) - 1);

  logic              clk;
  logic              reset;
  logic              cyc;
  logic              stb;
  logic              we;
  logic [2:0]        adr;
  logic [DATA_W-1:0] dat_w;
  logic [DATA_W-1:0] dat_r;
  logic              ack;

  int          error_count;
  int          check_count;
  int          cycle_count;
  logic [31:0] lfsr_q;

  // expected result per outstanding tag
  logic              pend_valid [NUM_TAGS];
  logic [DATA_W-1:0] pend_quot  [NUM_TAGS];
  logic [DATA_W-1:0] pend_rem   [NUM_TAGS];

  logic [ROW_W-1:0] burst_q   [$];
  logic [ROW_W-1:0] rand_rows [RAND_ROWS];

  div_array_top #(
    .NUM_LANES    (NUM_LANES),
    .RESULT_DEPTH (RESULT_DEPTH)
  ) div_array_top_i (
    .clk   (clk),
    .reset (reset),
    .cyc   (cyc),
    .stb   (stb),
    .we    (we),
    .adr   (adr),
    .dat_w (dat_w),
    .dat_r (dat_r),
    .ack   (ack)
  );

  always #50 clk = ~clk;

  // run limit
  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("timeout: run went past %0d cycles without finishing", CYCLE_LIMIT);
      $display("TB FAILED");
      $finish;
    end
  end

  // ------------------------------------------------------------
  // reference model by the restoring rule with sign fixup
  // ------------------------------------------------------------
  function automatic logic [2*DATA_W-1:0] expected_result(input fn_e fn,
                                                          input logic [DATA_W-1:0] a,
                                                          input logic [DATA_W-1:0] b);
    logic [DATA_W-1:0] ua;
    logic [DATA_W-1:0] ub;
    logic [DATA_W-1:0] q;
    logic [DATA_W-1:0] r;
    logic              neg_q;
    logic              neg_r;
    ua    = a;
    ub    = b;
    neg_q = 1'b0;
    neg_r = 1'b0;
    if (fn == FN_SIGNED) begin
      neg_q = a[DATA_W-1] ^ b[DATA_W-1];
      neg_r = a[DATA_W-1];
      if (a[DATA_W-1]) ua = 32'd0 - a;
      if (b[DATA_W-1]) ub = 32'd0 - b;
    end
    // a zero divisor keeps every difference
    if (ub == '0) begin
      q = '1;
      r = ua;
    end else begin
      q = ua / ub;
      r = ua % ub;
    end
    if (neg_q) q = 32'd0 - q;
    if (neg_r) r = 32'd0 - r;
    return {q, r};
  endfunction

  // fibonacci LFSR with taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  task automatic draw_bits(input int n, output logic [31:0] val);
    val = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_step(lfsr_q);
      val    = {val[30:0], lfsr_q[0]};
    end
  endtask

  // ------------------------------------------------------------
  // wishbone accesses
  // ------------------------------------------------------------
  task automatic wait_for_ack();
    do begin
      @(posedge clk);
      #1;
    end while (!ack);
  endtask

  task automatic write_reg(input logic [2:0] addr, input logic [DATA_W-1:0] data);
    @(posedge clk);
    #1;
    cyc   = 1'b1;
    stb   = 1'b1;
    we    = 1'b1;
    adr   = addr;
    dat_w = data;
    wait_for_ack();
    cyc = 1'b0;
    stb = 1'b0;
    we  = 1'b0;
  endtask

  task automatic read_reg(input logic [2:0] addr, output logic [DATA_W-1:0] data);
    @(posedge clk);
    #1;
    cyc = 1'b1;
    stb = 1'b1;
    we  = 1'b0;
    adr = addr;
    wait_for_ack();
    data = dat_r;
    cyc  = 1'b0;
    stb  = 1'b0;
  endtask

  task automatic check_value(input string what, input logic [DATA_W-1:0] got,
                             input logic [DATA_W-1:0] expected);
    check_count++;
    if (got !== expected) begin
      $display("mismatch at %0t: %s got %h expected %h", $time, what, got, expected);
      error_count++;
    end
  endtask

  // ------------------------------------------------------------
  // commands and results
  // ------------------------------------------------------------
  task automatic launch_row(input logic [ROW_W-1:0] row);
    fn_e                 fn;
    logic [DATA_W-1:0]   a;
    logic [DATA_W-1:0]   b;
    logic [DATA_W-1:0]   cmd;
    logic [TAG_W-1:0]    tag;
    logic [2*DATA_W-1:0] exp;
    fn  = fn_e'(row[ROW_W-1]);
    a   = row[ROW_W-2 -: DATA_W];
    b   = row[TAG_W +: DATA_W];
    tag = row[TAG_W-1:0];
    if (pend_valid[tag]) begin
      $display("tag %0d launched again while its result is still outstanding", tag);
      error_count++;
    end
    write_reg(REG_OPA, a);
    write_reg(REG_OPB, b);
    cmd                         = '0;
    cmd[CMD_FN_BIT]             = fn;
    cmd[CMD_TAG_LSB +: TAG_W]   = tag;
    // held by the front end while every lane is busy
    write_reg(REG_CMD, cmd);
    exp             = expected_result(fn, a, b);
    pend_valid[tag] = 1'b1;
    pend_quot[tag]  = exp[2*DATA_W-1:DATA_W];
    pend_rem[tag]   = exp[DATA_W-1:0];
  endtask

  task automatic collect_result();
    logic [DATA_W-1:0] st;
    logic [DATA_W-1:0] q;
    logic [DATA_W-1:0] r;
    logic [TAG_W-1:0]  tag;
    int                polls;
    polls = 0;
    read_reg(REG_STATUS, st);
    while (!st[STAT_AVAIL_BIT] && polls < POLL_LIMIT) begin
      read_reg(REG_STATUS, st);
      polls++;
    end
    if (!st[STAT_AVAIL_BIT]) begin
      $display("no result became available after %0d status polls", POLL_LIMIT);
      error_count++;
      return;
    end
    tag = st[STAT_TAG_LSB +: TAG_W];
    read_reg(REG_QUOT, q);
    // the REM read pops the head
    read_reg(REG_REM, r);
    if (!pend_valid[tag]) begin
      $display("result with tag %0d arrived but was not outstanding", tag);
      error_count++;
    end else begin
      check_value($sformatf("dat_r (REG_QUOT) tag %0d", tag), q, pend_quot[tag]);
      check_value($sformatf("dat_r (REG_REM) tag %0d", tag), r, pend_rem[tag]);
      pend_valid[tag] = 1'b0;
    end
  endtask

  // every launched tag came back and nothing is left behind
  task automatic check_drained();
    logic [DATA_W-1:0] st;
    for (int t = 0; t < NUM_TAGS; t++) begin
      if (pend_valid[t]) begin
        $display("tag %0d was launched but its result never came back", t);
        error_count++;
        pend_valid[t] = 1'b0;
      end
    end
    read_reg(REG_STATUS, st);
    check_value("status avail after drain", st[STAT_AVAIL_BIT], 32'd0);
  endtask

  task automatic run_burst();
    int n;
    n = burst_q.size();
    foreach (burst_q[i]) begin
      launch_row(burst_q[i]);
    end
    repeat (n) collect_result();
    check_drained();
    burst_q.delete();
  endtask

  task automatic report_test(input string name, input int errs_before);
    if (error_count == errs_before) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: %0d errors", name, error_count - errs_before);
    end
  endtask

  // ------------------------------------------------------------
  // test sequence
  // ------------------------------------------------------------
  initial begin
    logic [DATA_W-1:0] st;
    logic [DATA_W-1:0] rd;
    logic [31:0]       bits_fn;
    logic [31:0]       bits_a;
    logic [31:0]       bits_b;
    logic [31:0]       bits_sh;
    int                errs_before;
    clk         = 1'b0;
    reset       = 1'b1;
    cyc         = 1'b0;
    stb         = 1'b0;
    we          = 1'b0;
    adr         = '0;
    dat_w       = '0;
    error_count = 0;
    check_count = 0;
    cycle_count = 0;
    lfsr_q      = 32'hd862;
    for (int t = 0; t < NUM_TAGS; t++) begin
      pend_valid[t] = 1'b0;
    end
    repeat (3) @(posedge clk);
    #1;
    reset = 1'b0;

    // idle state after reset and an empty queue reading as zero
    errs_before = error_count;
    read_reg(REG_STATUS, st);
    check_value("status avail", st[STAT_AVAIL_BIT], 32'd0);
    check_value("status idle mask", st[STAT_MASK_LSB +: STAT_MASK_W], ALL_IDLE);
    read_reg(REG_QUOT, rd);
    check_value("dat_r (REG_QUOT) empty", rd, 32'd0);
    read_reg(REG_REM, rd);
    check_value("dat_r (REG_REM) empty", rd, 32'd0);
    read_reg(REG_STATUS, st);
    check_value("status avail after empty pop", st[STAT_AVAIL_BIT], 32'd0);
    report_test("reset status", errs_before);

    errs_before = error_count;
    for (int i = 0; i < UNSIGNED_ROWS; i++) begin
      burst_q.push_back(vector_row(i));
      if (burst_q.size() == BURST || i == UNSIGNED_ROWS - 1) run_burst();
    end
    report_test("unsigned table", errs_before);

    errs_before = error_count;
    for (int i = UNSIGNED_ROWS; i < TABLE_ROWS; i++) begin
      burst_q.push_back(vector_row(i));
      if (burst_q.size() == BURST || i == TABLE_ROWS - 1) run_burst();
    end
    report_test("signed table", errs_before);

    // two more commands than lanes so the idle mask reaches zero
    errs_before = error_count;
    for (int i = 0; i < NUM_LANES + 2; i++) begin
      launch_row(vector_row(i));
      if (i == NUM_LANES - 1) begin
        read_reg(REG_STATUS, st);
        check_value("status idle mask busy", st[STAT_MASK_LSB +: STAT_MASK_W], 32'd0);
      end
    end
    repeat (NUM_LANES + 2) collect_result();
    check_drained();
    report_test("back to back", errs_before);

    // fill the queue and every lane before any read
    errs_before = error_count;
    for (int i = 0; i < NUM_LANES + RESULT_DEPTH; i++) begin
      launch_row(vector_row(UNSIGNED_ROWS + i));
    end
    // the last lanes finish behind a full queue and must hold their results
    repeat (LANE_CYCLES) @(posedge clk);
    read_reg(REG_STATUS, st);
    check_value("status avail full", st[STAT_AVAIL_BIT], 32'd1);
    check_value("status idle mask full", st[STAT_MASK_LSB +: STAT_MASK_W], 32'd0);
    repeat (NUM_LANES + RESULT_DEPTH) collect_result();
    check_drained();
    report_test("queue back-pressure", errs_before);

    errs_before = error_count;
    for (int i = 0; i < RAND_ROWS; i++) begin
      draw_bits(1, bits_fn);
      draw_bits(32, bits_a);
      draw_bits(32, bits_b);
      draw_bits(2, bits_sh);
      // small divisors now and then
      if (bits_sh[1:0] == 2'd0) bits_b = bits_b >> 24;
      rand_rows[i] = {bits_fn[0], bits_a, bits_b, TAG_W'(i)};
    end
    for (int i = 0; i < RAND_ROWS; i++) begin
      burst_q.push_back(rand_rows[i]);
      if (burst_q.size() == BURST || i == RAND_ROWS - 1) run_burst();
    end
    report_test("random rows", errs_before);

    $display("checks %0d, errors %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

/* design/div_array_top.sv */
// divide coprocessor top level
// wishbone front end, NUM_LANES divider lanes, result collector
`timescale 1ns/1ps

module div_array_top #(
  parameter int NUM_LANES    = 4,
  parameter int RESULT_DEPTH = 4
) (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       cyc,
  input  logic                       stb,
  input  logic                       we,
  input  logic [2:0]                 adr,
  input  logic [div_pkg::DATA_W-1:0] dat_w,
  output logic [div_pkg::DATA_W-1:0] dat_r,
  output logic                       ack
);

  import div_pkg::*;

  // request side, payload shared by every lane
  logic [NUM_LANES-1:0] req_val;
  logic [NUM_LANES-1:0] req_rdy;
  fn_e                  req_fn;
  logic [DATA_W-1:0]    req_a;
  logic [DATA_W-1:0]    req_b;
  logic [TAG_W-1:0]     req_tag;

  // response side, one slice per lane
  logic [NUM_LANES-1:0]             resp_val;
  logic [NUM_LANES-1:0]             resp_rdy;
  logic [NUM_LANES-1:0][DATA_W-1:0] resp_quot;
  logic [NUM_LANES-1:0][DATA_W-1:0] resp_rem;
  logic [NUM_LANES-1:0][TAG_W-1:0]  resp_tag;

  // queue head
  logic              head_val;
  logic [TAG_W-1:0]  head_tag;
  logic [DATA_W-1:0] head_quot;
  logic [DATA_W-1:0] head_rem;
  logic              pop;

  div_wb_front #(
    .NUM_LANES (NUM_LANES)
  ) front_i (
    .clk          (clk),
    .reset        (reset),
    .cyc          (cyc),
    .stb          (stb),
    .we           (we),
    .adr          (adr),
    .dat_w        (dat_w),
    .dat_r        (dat_r),
    .ack          (ack),
    .lane_req_val (req_val),
    .lane_req_rdy (req_rdy),
    .req_fn       (req_fn),
    .req_a        (req_a),
    .req_b        (req_b),
    .req_tag      (req_tag),
    .head_val     (head_val),
    .head_tag     (head_tag),
    .head_quot    (head_quot),
    .head_rem     (head_rem),
    .pop          (pop)
  );

  // ------------------------------------------------------------
  // divider lanes
  // ------------------------------------------------------------
  for (genvar g = 0; g < NUM_LANES; g++) begin : g_lane
    div_lane lane_i (
      .clk       (clk),
      .reset     (reset),
      .req_val   (req_val[g]),
      .req_rdy   (req_rdy[g]),
      .req_fn    (req_fn),
      .req_a     (req_a),
      .req_b     (req_b),
      .req_tag   (req_tag),
      .resp_val  (resp_val[g]),
      .resp_rdy  (resp_rdy[g]),
      .resp_quot (resp_quot[g]),
      .resp_rem  (resp_rem[g]),
      .resp_tag  (resp_tag[g])
    );
  end

  div_collect #(
    .NUM_LANES    (NUM_LANES),
    .RESULT_DEPTH (RESULT_DEPTH)
  ) collect_i (
    .clk           (clk),
    .reset         (reset),
    .lane_resp_val (resp_val),
    .lane_resp_rdy (resp_rdy),
    .lane_quot     (resp_quot),
    .lane_rem      (resp_rem),
    .lane_tag      (resp_tag),
    .head_val      (head_val),
    .head_tag      (head_tag),
    .head_quot     (head_quot),
    .head_rem      (head_rem),
    .pop           (pop)
  );

endmodule

/* design/div_collect.sv */
// result collector
// round-robin drain of finished lanes into a circular result queue
`timescale 1ns/1ps

module div_collect #(
  parameter int NUM_LANES    = 4,
  parameter int RESULT_DEPTH = 4
) (
  input  logic                                      clk,
  input  logic                                      reset,
  input  logic [NUM_LANES-1:0]                      lane_resp_val,
  output logic [NUM_LANES-1:0]                      lane_resp_rdy,
  input  logic [NUM_LANES-1:0][div_pkg::DATA_W-1:0] lane_quot,
  input  logic [NUM_LANES-1:0][div_pkg::DATA_W-1:0] lane_rem,
  input  logic [NUM_LANES-1:0][div_pkg::TAG_W-1:0]  lane_tag,
  output logic                                      head_val,
  output logic [div_pkg::TAG_W-1:0]                 head_tag,
  output logic [div_pkg::DATA_W-1:0]                head_quot,
  output logic [div_pkg::DATA_W-1:0]                head_rem,
  input  logic                                      pop
);

  import div_pkg::*;

  localparam int LANE_W = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;
  localparam int PTR_W  = (RESULT_DEPTH > 1) ? $clog2(RESULT_DEPTH) : 1;
  localparam int CNT_W  = $clog2(RESULT_DEPTH + 1);

  logic [LANE_W-1:0] last_q;
  logic [LANE_W-1:0] sel;
  logic              found;
  logic              full;
  logic              push;
  logic              do_pop;
  logic [PTR_W-1:0]  wr_ptr_q;
  logic [PTR_W-1:0]  rd_ptr_q;
  logic [CNT_W-1:0]  count_q;

  logic [DATA_W-1:0] q_quot [RESULT_DEPTH];
  logic [DATA_W-1:0] q_rem  [RESULT_DEPTH];
  logic [TAG_W-1:0]  q_tag  [RESULT_DEPTH];

  // ------------------------------------------------------------
  // round-robin pick, search starts one past the last grant
  // ------------------------------------------------------------
  always_comb begin
    int idx;
    found = 1'b0;
    sel   = last_q;
    for (int i = 1; i <= NUM_LANES; i++) begin
      idx = (int'(last_q) + i) % NUM_LANES;
      if (!found && lane_resp_val[idx]) begin
        found = 1'b1;
        sel   = LANE_W'(idx);
      end
    end
  end

  assign full   = (count_q == CNT_W'(RESULT_DEPTH));
  assign push   = found && !full;
  assign do_pop = pop && head_val;

  always_comb begin
    lane_resp_rdy = '0;
    if (push) begin
      lane_resp_rdy[sel] = 1'b1;
    end
  end

  // ------------------------------------------------------------
  // queue pointers and storage
  // ------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      // lane 0 gets first pick after reset
      last_q   <= LANE_W'(NUM_LANES - 1);
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        last_q   <= sel;
        wr_ptr_q <= (wr_ptr_q == PTR_W'(RESULT_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(RESULT_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      if (push && !do_pop) begin
        count_q <= count_q + 1'b1;
      end else if (!push && do_pop) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      q_quot[wr_ptr_q] <= lane_quot[sel];
      q_rem[wr_ptr_q]  <= lane_rem[sel];
      q_tag[wr_ptr_q]  <= lane_tag[sel];
    end
  end

  assign head_val  = (count_q != '0);
  assign head_tag  = q_tag[rd_ptr_q];
  assign head_quot = q_quot[rd_ptr_q];
  assign head_rem  = q_rem[rd_ptr_q];

endmodule

/* design/div_wb_front.sv */
// wishbone classic slave front end
// operand registers, command dispatch to the lowest idle lane, result reads
`timescale 1ns/1ps

module div_wb_front #(
  parameter int NUM_LANES = 4
) (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       cyc,
  input  logic                       stb,
  input  logic                       we,
  input  logic [2:0]                 adr,
  input  logic [div_pkg::DATA_W-1:0] dat_w,
  output logic [div_pkg::DATA_W-1:0] dat_r,
  output logic                       ack,
  output logic [NUM_LANES-1:0]       lane_req_val,
  input  logic [NUM_LANES-1:0]       lane_req_rdy,
  output div_pkg::fn_e               req_fn,
  output logic [div_pkg::DATA_W-1:0] req_a,
  output logic [div_pkg::DATA_W-1:0] req_b,
  output logic [div_pkg::TAG_W-1:0]  req_tag,
  input  logic                       head_val,
  input  logic [div_pkg::TAG_W-1:0]  head_tag,
  input  logic [div_pkg::DATA_W-1:0] head_quot,
  input  logic [div_pkg::DATA_W-1:0] head_rem,
  output logic                       pop
);

  import div_pkg::*;

  wb_reg_e reg_sel;
  logic    any_rdy;
  logic    rd_go;
  logic    wr_go;
  logic    cmd_go;
  logic [NUM_LANES-1:0]   pick;
  logic [STAT_MASK_W-1:0] idle_mask;
  logic [DATA_W-1:0]      status;
  logic [DATA_W-1:0]      rd_data;
  logic [DATA_W-1:0]      opa_q;
  logic [DATA_W-1:0]      opb_q;

  assign reg_sel = wb_reg_e'(adr);
  assign any_rdy = |lane_req_rdy;

  // ------------------------------------------------------------
  // bus cycle decode
  // ------------------------------------------------------------
  // the !ack term keeps a cycle from being taken twice
  assign rd_go  = cyc && stb && !we && !ack;
  // command writes wait here until some lane is idle
  assign wr_go  = cyc && stb && we && !ack && (reg_sel != REG_CMD || any_rdy);
  assign cmd_go = wr_go && (reg_sel == REG_CMD);

  // lowest set bit of the ready vector
  assign pick         = lane_req_rdy & (~lane_req_rdy + 1'b1);
  assign lane_req_val = cmd_go ? pick : '0;

  // function and tag straight from the command word
  assign req_fn  = fn_e'(dat_w[CMD_FN_BIT]);
  assign req_tag = dat_w[CMD_TAG_LSB +: TAG_W];
  assign req_a   = opa_q;
  assign req_b   = opb_q;

  always_ff @(posedge clk) begin
    if (reset) begin
      ack <= 1'b0;
      pop <= 1'b0;
    end else begin
      ack <= rd_go || wr_go;
      // pop goes out together with the ack of a REM read
      pop <= rd_go && (reg_sel == REG_REM) && head_val;
    end
  end

  always_ff @(posedge clk) begin
    if (wr_go && reg_sel == REG_OPA) begin
      opa_q <= dat_w;
    end
    if (wr_go && reg_sel == REG_OPB) begin
      opb_q <= dat_w;
    end
  end

  // ------------------------------------------------------------
  // read side
  // ------------------------------------------------------------
  assign idle_mask = STAT_MASK_W'(lane_req_rdy);

  always_comb begin
    status = '0;
    status[STAT_AVAIL_BIT]                = head_val;
    status[STAT_TAG_LSB +: TAG_W]         = head_tag;
    status[STAT_MASK_LSB +: STAT_MASK_W]  = idle_mask;
  end

  always_comb begin
    case (reg_sel)
      REG_OPA:    rd_data = opa_q;
      REG_OPB:    rd_data = opb_q;
      REG_STATUS: rd_data = status;
      // empty queue reads back as zero
      REG_QUOT:   rd_data = head_val ? head_quot : '0;
      REG_REM:    rd_data = head_val ? head_rem : '0;
      default:    rd_data = '0;
    endcase
  end

  // data is sampled with the head before any pop
  always_ff @(posedge clk) begin
    if (rd_go) begin
      dat_r <= rd_data;
    end
  end

endmodule

/* design/div_lane.sv */
// one divider lane
// control FSM plus datapath, tag travels alongside the operation
`timescale 1ns/1ps

module div_lane (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       req_val,
  output logic                       req_rdy,
  input  div_pkg::fn_e               req_fn,
  input  logic [div_pkg::DATA_W-1:0] req_a,
  input  logic [div_pkg::DATA_W-1:0] req_b,
  input  logic [div_pkg::TAG_W-1:0]  req_tag,
  output logic                       resp_val,
  input  logic                       resp_rdy,
  output logic [div_pkg::DATA_W-1:0] resp_quot,
  output logic [div_pkg::DATA_W-1:0] resp_rem,
  output logic [div_pkg::TAG_W-1:0]  resp_tag
);

  import div_pkg::*;

  logic load;
  logic step;
  logic fix;
  logic cnt_zero;
  logic [TAG_W-1:0] tag_q;

  div_lane_ctrl ctrl_i (
    .clk      (clk),
    .reset    (reset),
    .req_val  (req_val),
    .req_rdy  (req_rdy),
    .resp_val (resp_val),
    .resp_rdy (resp_rdy),
    .cnt_zero (cnt_zero),
    .load     (load),
    .step     (step),
    .fix      (fix)
  );

  div_lane_dpath dpath_i (
    .clk      (clk),
    .reset    (reset),
    .load     (load),
    .step     (step),
    .fix      (fix),
    .req_fn   (req_fn),
    .req_a    (req_a),
    .req_b    (req_b),
    .cnt_zero (cnt_zero),
    .quot     (resp_quot),
    .rem      (resp_rem)
  );

  // tag captured with the operands
  always_ff @(posedge clk) begin
    if (load) begin
      tag_q <= req_tag;
    end
  end

  assign resp_tag = tag_q;

endmodule

/* design/div_lane_ctrl.sv */
// divider lane control FSM
// idle, calc, fix, done with request and response val/rdy handshakes
`timescale 1ns/1ps

module div_lane_ctrl (
  input  logic clk,
  input  logic reset,
  input  logic req_val,
  output logic req_rdy,
  output logic resp_val,
  input  logic resp_rdy,
  input  logic cnt_zero,
  output logic load,
  output logic step,
  output logic fix
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_CALC,
    ST_FIX,
    ST_DONE
  } state_e;

  state_e state_q;
  state_e state_d;

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE: begin
        if (req_val) begin
          state_d = ST_CALC;
        end
      end
      ST_CALC: begin
        // last of 32 steps when the counter reads zero
        if (cnt_zero) begin
          state_d = ST_FIX;
        end
      end
      ST_FIX: begin
        state_d = ST_DONE;
      end
      ST_DONE: begin
        // hold the result until the collector takes it
        if (resp_rdy) begin
          state_d = ST_IDLE;
        end
      end
      default: begin
        state_d = ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state_q <= ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // handshakes and datapath enables
  assign req_rdy  = (state_q == ST_IDLE);
  assign resp_val = (state_q == ST_DONE);
  assign load     = req_val && req_rdy;
  assign step     = (state_q == ST_CALC);
  assign fix      = (state_q == ST_FIX);

endmodule

/* design/div_lane_dpath.sv */
// divider lane datapath
// restoring shift-subtract over a 65-bit remainder/quotient pair, with sign fixup
`timescale 1ns/1ps

module div_lane_dpath (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       load,
  input  logic                       step,
  input  logic                       fix,
  input  div_pkg::fn_e               req_fn,
  input  logic [div_pkg::DATA_W-1:0] req_a,
  input  logic [div_pkg::DATA_W-1:0] req_b,
  output logic                       cnt_zero,
  output logic [div_pkg::DATA_W-1:0] quot,
  output logic [div_pkg::DATA_W-1:0] rem
);

  import div_pkg::*;

  // ------------------------------------------------------------
  // operand unsigning
  // ------------------------------------------------------------
  logic            is_signed;
  logic [DATA_W-1:0] mag_a;
  logic [DATA_W-1:0] mag_b;

  assign is_signed = (req_fn == FN_SIGNED);

  // magnitudes only taken for signed requests
  assign mag_a = (is_signed && req_a[DATA_W-1]) ? -req_a : req_a;
  assign mag_b = (is_signed && req_b[DATA_W-1]) ? -req_b : req_b;

  // ------------------------------------------------------------
  // iteration state
  // ------------------------------------------------------------
  // upper 33 bits partial remainder, lower 32 bits quotient
  logic [2*DATA_W:0]   pair_q;
  logic [DATA_W-1:0]   dvs_q;
  logic                neg_quot_q;
  logic                neg_rem_q;
  logic [4:0]          cnt_q;

  logic [2*DATA_W:0]   shifted;
  logic [2*DATA_W:0]   diff;

  assign shifted = {pair_q[2*DATA_W-1:0], 1'b0};
  // divisor lines up with the remainder half
  assign diff    = shifted - {1'b0, dvs_q, {DATA_W{1'b0}}};

  // iteration counter, 31 down to 0 gives 32 steps
  always_ff @(posedge clk) begin
    if (reset) begin
      cnt_q <= 5'd0;
    end else if (load) begin
      cnt_q <= 5'd31;
    end else if (step && cnt_q != 5'd0) begin
      cnt_q <= cnt_q - 5'd1;
    end
  end

  assign cnt_zero = (cnt_q == 5'd0);

  always_ff @(posedge clk) begin
    if (load) begin
      pair_q     <= {{(DATA_W+1){1'b0}}, mag_a};
      dvs_q      <= mag_b;
      // quotient sign follows both operands, remainder follows dividend
      neg_quot_q <= is_signed && (req_a[DATA_W-1] ^ req_b[DATA_W-1]);
      neg_rem_q  <= is_signed && req_a[DATA_W-1];
    end else if (step) begin
      if (diff[2*DATA_W]) begin
        // negative difference, restore and shift in 0
        pair_q <= shifted;
      end else begin
        // keep the difference, quotient bit 1
        pair_q <= {diff[2*DATA_W:1], 1'b1};
      end
    end else if (fix) begin
      if (neg_quot_q) begin
        pair_q[DATA_W-1:0] <= -pair_q[DATA_W-1:0];
      end
      if (neg_rem_q) begin
        pair_q[2*DATA_W-1:DATA_W] <= -pair_q[2*DATA_W-1:DATA_W];
      end
    end
  end

  // ------------------------------------------------------------
  // results
  // ------------------------------------------------------------
  assign quot = pair_q[DATA_W-1:0];
  assign rem  = pair_q[2*DATA_W-1:DATA_W];

endmodule

/* design/div_pkg.sv */
// divide coprocessor shared definitions
// bus register map, command and status field positions, widths
package div_pkg;

  // ------------------------------------------------------------
  // widths
  // ------------------------------------------------------------
  // operand, result and bus data width
  localparam int DATA_W = 32;
  // software tag carried with each command and result
  localparam int TAG_W  = 4;

  // function bit of a command
  typedef enum logic {
    FN_UNSIGNED = 1'b0,
    FN_SIGNED   = 1'b1
  } fn_e;

  // ------------------------------------------------------------
  // wishbone word addresses
  // ------------------------------------------------------------
  typedef enum logic [2:0] {
    REG_OPA    = 3'd0,
    REG_OPB    = 3'd1,
    REG_CMD    = 3'd2,
    REG_STATUS = 3'd3,
    REG_QUOT   = 3'd4,
    REG_REM    = 3'd5
  } wb_reg_e;

  // command word layout
  localparam int CMD_FN_BIT  = 0;
  localparam int CMD_TAG_LSB = 4;

  // status word layout
  localparam int STAT_AVAIL_BIT = 0;
  localparam int STAT_TAG_LSB   = 4;
  localparam int STAT_MASK_LSB  = 8;
  // idle mask field, wide enough for up to 8 lanes
  localparam int STAT_MASK_W    = 8;

endpackage
